//--- lsu_params.svh
// load/store slice parameters: lane count, data width and tag field widths
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

`define LSU_NUM_LANES   4
`define LSU_XLEN        32
`define LSU_WORD_BYTES  4
`define LSU_ALIGN_W     2
`define LSU_OP_W        4
`define LSU_UUID_W      8
`define LSU_WID_W       2
`define LSU_PC_W        30
`define LSU_NR_W        5
`define LSU_OFFSET_W    12

// uuid + wid + pc + wb + rd + op + per-lane align + is_fence
`define LSU_TAG_W (`LSU_UUID_W + `LSU_WID_W + `LSU_PC_W + 1 + `LSU_NR_W + `LSU_OP_W \
                   + (`LSU_NUM_LANES * `LSU_ALIGN_W) + 1)

`define LSU_BUF_DEPTH   2

`endif

//--- lsu_pkg.sv
// load/store slice types: lane vectors, instruction fields and the operation enum
`include "lsu_params.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]               xword_t;
    typedef logic [`LSU_XLEN-`LSU_ALIGN_W-1:0]  maddr_t;
    typedef logic [`LSU_WORD_BYTES-1:0]         byteen_t;
    typedef logic [`LSU_ALIGN_W-1:0]            align_t;
    typedef logic [`LSU_NUM_LANES-1:0]          lane_mask_t;
    typedef logic [`LSU_UUID_W-1:0]             uuid_t;
    typedef logic [`LSU_WID_W-1:0]              wid_t;
    typedef logic [`LSU_PC_W-1:0]               pc_t;
    typedef logic [`LSU_NR_W-1:0]               rd_t;
    typedef logic [`LSU_TAG_W-1:0]              mem_tag_t;

    // bits [1:0] access size, bit 2 unsigned, bit 3 store
    typedef enum logic [`LSU_OP_W-1:0] {
        LB    = 4'h0,
        LH    = 4'h1,
        LW    = 4'h2,
        LBU   = 4'h4,
        LHU   = 4'h5,
        SB    = 4'h8,
        SH    = 4'h9,
        SW    = 4'ha,
        FENCE = 4'hf
    } lsu_op_e;

endpackage

//--- lsu_req_format.sv
// request formatter: per-lane address generation, byte enables and store data alignment
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_req_format (
    input  lsu_pkg::lsu_op_e                        exe_op,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    rs1_data,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    rs2_data,
    input  logic [`LSU_OFFSET_W-1:0]                offset,
    output lsu_pkg::maddr_t [`LSU_NUM_LANES-1:0]    mem_addr,
    output lsu_pkg::align_t [`LSU_NUM_LANES-1:0]    align,
    output lsu_pkg::byteen_t [`LSU_NUM_LANES-1:0]   byteen,
    output lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    store_data
);
    import lsu_pkg::*;

    xword_t offset_sext;

    assign offset_sext = {{(`LSU_XLEN-`LSU_OFFSET_W){offset[`LSU_OFFSET_W-1]}}, offset};

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        xword_t  full_addr;
        byteen_t byteen_w;

        assign full_addr = rs1_data[i] + offset_sext;

        assign mem_addr[i] = full_addr[`LSU_XLEN-1:`LSU_ALIGN_W];
        assign align[i]    = full_addr[`LSU_ALIGN_W-1:0];

        always_comb begin
            byteen_w = '0;
            case (exe_op)
                LB, LBU, SB: begin
                    byteen_w[full_addr[`LSU_ALIGN_W-1:0]] = 1'b1;
                end
                LH, LHU, SH: begin
                    // aligned half, low or high pair
                    byteen_w[{full_addr[1], 1'b0}] = 1'b1;
                    byteen_w[{full_addr[1], 1'b1}] = 1'b1;
                end
                default: begin
                    byteen_w = '1;
                end
            endcase
        end

        assign byteen[i] = byteen_w;

        // move the store bytes up to their lane position
        assign store_data[i] = rs2_data[i] << {full_addr[`LSU_ALIGN_W-1:0], 3'b000};
    end

endmodule

//--- lsu_issue_ctrl.sv
// issue control: execute handshake steering, fence lock and memory tag packing
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_issue_ctrl (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    exe_valid,
    input  lsu_pkg::lsu_op_e                        exe_op,
    input  logic                                    exe_wb,
    input  lsu_pkg::uuid_t                          exe_uuid,
    input  lsu_pkg::wid_t                           exe_wid,
    input  lsu_pkg::pc_t                            exe_pc,
    input  lsu_pkg::rd_t                            exe_rd,
    input  lsu_pkg::align_t [`LSU_NUM_LANES-1:0]    align,
    input  logic                                    mem_req_ready,
    input  logic                                    nrsp_ready,
    input  logic                                    rsp_fire,
    input  logic                                    rsp_is_fence,
    output logic                                    exe_ready,
    output logic                                    mem_req_valid,
    output logic                                    mem_req_rw,
    output logic                                    mem_req_flush,
    output lsu_pkg::mem_tag_t                       mem_req_tag,
    output logic                                    nrsp_valid
);
    import lsu_pkg::*;

    logic req_is_store;
    logic req_is_fence;
    logic nrsp_enable;
    logic nrsp_blocked;
    logic mem_req_fire;
    logic fence_lock;

    assign req_is_store = (exe_op == SB) || (exe_op == SH) || (exe_op == SW);
    assign req_is_fence = (exe_op == FENCE);

    // stores without writeback commit through the no-response path
    assign nrsp_enable  = req_is_store && !exe_wb;
    assign nrsp_blocked = nrsp_enable && !nrsp_ready;

    assign mem_req_valid = exe_valid && !fence_lock && !nrsp_blocked;
    assign nrsp_valid    = exe_valid && nrsp_enable && mem_req_ready && !fence_lock;
    assign exe_ready     = mem_req_ready && !fence_lock && !nrsp_blocked;

    assign mem_req_fire  = mem_req_valid && mem_req_ready;
    assign mem_req_rw    = req_is_store;
    assign mem_req_flush = req_is_fence;

    always_ff @(posedge clk) begin
        if (reset) begin
            fence_lock <= 1'b0;
        end else begin
            if (mem_req_fire && req_is_fence) begin
                fence_lock <= 1'b1;
            end
            if (rsp_fire && rsp_is_fence) begin
                fence_lock <= 1'b0;
            end
        end
    end

    assign mem_req_tag = {
        exe_uuid,
        exe_wid,
        exe_pc,
        exe_wb,
        exe_rd,
        exe_op,
        align,
        req_is_fence
    };

endmodule

//--- lsu_rsp_format.sv
// response formatter: tag unpacking and per-lane load data extraction and extension
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_rsp_format (
    input  lsu_pkg::mem_tag_t                       mem_rsp_tag,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    mem_rsp_data,
    output lsu_pkg::uuid_t                          rsp_uuid,
    output lsu_pkg::wid_t                           rsp_wid,
    output lsu_pkg::pc_t                            rsp_pc,
    output logic                                    rsp_wb,
    output lsu_pkg::rd_t                            rsp_rd,
    output logic                                    rsp_is_fence,
    output lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    rsp_data
);
    import lsu_pkg::*;

    logic [`LSU_OP_W-1:0]           rsp_op;
    align_t [`LSU_NUM_LANES-1:0]    rsp_align;

    assign {
        rsp_uuid,
        rsp_wid,
        rsp_pc,
        rsp_wb,
        rsp_rd,
        rsp_op,
        rsp_align,
        rsp_is_fence
    } = mem_rsp_tag;

    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_lane
        logic [15:0] data16;
        logic [7:0]  data8;
        xword_t      lane_data;

        // half first, then byte within it
        assign data16 = rsp_align[i][1] ? mem_rsp_data[i][31:16] : mem_rsp_data[i][15:0];
        assign data8  = rsp_align[i][0] ? data16[15:8] : data16[7:0];

        always_comb begin
            case (rsp_op)
                LB:      lane_data = {{(`LSU_XLEN-8){data8[7]}}, data8};
                LH:      lane_data = {{(`LSU_XLEN-16){data16[15]}}, data16};
                LBU:     lane_data = {{(`LSU_XLEN-8){1'b0}}, data8};
                LHU:     lane_data = {{(`LSU_XLEN-16){1'b0}}, data16};
                LW:      lane_data = mem_rsp_data[i];
                // fence and anything else returns zero
                default: lane_data = '0;
            endcase
        end

        assign rsp_data[i] = lane_data;
    end

endmodule

//--- lsu_commit_buf.sv
// elastic buffer: small FIFO that decouples a commit path from its producer
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_commit_buf #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  logic [WIDTH-1:0] data_in,
    input  logic             ready_out,
    output logic             ready_in,
    output logic             valid_out,
    output logic [WIDTH-1:0] data_out
);
    localparam int DEPTH = `LSU_BUF_DEPTH;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr;
    logic [AW-1:0]    rd_ptr;
    logic [AW:0]      count;
    logic             push;
    logic             pop;

    assign ready_in  = (count != (AW+1)'(DEPTH));
    assign valid_out = (count != '0);
    assign data_out  = mem[rd_ptr];

    assign push = valid_in && ready_in;
    assign pop  = valid_out && ready_out;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- lsu_commit_arb.sv
// commit arbiter: fixed priority between response and store paths, registered output
`timescale 1ns/100ps

module lsu_commit_arb #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             rsp_valid,
    input  logic [WIDTH-1:0] rsp_data,
    input  logic             nrsp_valid,
    input  logic [WIDTH-1:0] nrsp_data,
    input  logic             commit_ready,
    output logic             rsp_ready,
    output logic             nrsp_ready,
    output logic             commit_valid,
    output logic [WIDTH-1:0] commit_data
);
    logic             out_valid;
    logic [WIDTH-1:0] out_data;
    logic             load;

    // output register free or draining this cycle
    assign load = !out_valid || commit_ready;

    // response path wins, store path waits
    assign rsp_ready  = load;
    assign nrsp_ready = load && !rsp_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= rsp_valid || nrsp_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            if (rsp_valid) begin
                out_data <= rsp_data;
            end else if (nrsp_valid) begin
                out_data <= nrsp_data;
            end
        end
    end

    assign commit_valid = out_valid;
    assign commit_data  = out_data;

endmodule

//--- lsu_slice.sv
// load/store unit slice: request formatting, fence ordering, load formatting and commit merge
`timescale 1ns/100ps
`include "lsu_params.svh"

module lsu_slice (
    input  logic                                    clk,
    input  logic                                    reset,
    // execute
    input  logic                                    exe_valid,
    input  lsu_pkg::uuid_t                          exe_uuid,
    input  lsu_pkg::wid_t                           exe_wid,
    input  lsu_pkg::lane_mask_t                     exe_tmask,
    input  lsu_pkg::pc_t                            exe_pc,
    input  lsu_pkg::lsu_op_e                        exe_op,
    input  logic                                    exe_wb,
    input  lsu_pkg::rd_t                            exe_rd,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    exe_rs1_data,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    exe_rs2_data,
    input  logic [`LSU_OFFSET_W-1:0]                exe_offset,
    output logic                                    exe_ready,
    // memory request
    output logic                                    mem_req_valid,
    output logic                                    mem_req_rw,
    output lsu_pkg::lane_mask_t                     mem_req_mask,
    output lsu_pkg::byteen_t [`LSU_NUM_LANES-1:0]   mem_req_byteen,
    output lsu_pkg::maddr_t [`LSU_NUM_LANES-1:0]    mem_req_addr,
    output lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    mem_req_data,
    output logic                                    mem_req_flush,
    output lsu_pkg::mem_tag_t                       mem_req_tag,
    input  logic                                    mem_req_ready,
    // memory response
    input  logic                                    mem_rsp_valid,
    input  lsu_pkg::lane_mask_t                     mem_rsp_mask,
    input  lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    mem_rsp_data,
    input  lsu_pkg::mem_tag_t                       mem_rsp_tag,
    output logic                                    mem_rsp_ready,
    // commit
    output logic                                    commit_valid,
    output lsu_pkg::uuid_t                          commit_uuid,
    output lsu_pkg::wid_t                           commit_wid,
    output lsu_pkg::lane_mask_t                     commit_tmask,
    output lsu_pkg::pc_t                            commit_pc,
    output logic                                    commit_wb,
    output lsu_pkg::rd_t                            commit_rd,
    output lsu_pkg::xword_t [`LSU_NUM_LANES-1:0]    commit_data,
    input  logic                                    commit_ready
);
    import lsu_pkg::*;

    localparam int NRSP_W = `LSU_UUID_W + `LSU_WID_W + `LSU_NUM_LANES + `LSU_PC_W;
    localparam int RSP_W  = NRSP_W + 1 + `LSU_NR_W + (`LSU_NUM_LANES * `LSU_XLEN);

    align_t [`LSU_NUM_LANES-1:0] req_align;
    logic   nrsp_valid;
    logic   nrsp_ready;
    logic   rsp_fire;

    uuid_t  rsp_uuid;
    wid_t   rsp_wid;
    pc_t    rsp_pc;
    logic   rsp_wb;
    rd_t    rsp_rd;
    logic   rsp_is_fence;
    xword_t [`LSU_NUM_LANES-1:0] rsp_data;

    logic              rsp_buf_valid;
    logic              rsp_buf_ready;
    logic [RSP_W-1:0]  rsp_buf_data;
    logic              nrsp_buf_valid;
    logic              nrsp_buf_ready;
    logic [NRSP_W-1:0] nrsp_buf_data;
    logic [RSP_W-1:0]  arb_data;

    assign mem_req_mask = exe_tmask;
    assign rsp_fire     = mem_rsp_valid && mem_rsp_ready;

    lsu_req_format i_req_format (
        .exe_op     (exe_op),
        .rs1_data   (exe_rs1_data),
        .rs2_data   (exe_rs2_data),
        .offset     (exe_offset),
        .mem_addr   (mem_req_addr),
        .align      (req_align),
        .byteen     (mem_req_byteen),
        .store_data (mem_req_data)
    );

    lsu_issue_ctrl i_issue_ctrl (
        .clk           (clk),
        .reset         (reset),
        .exe_valid     (exe_valid),
        .exe_op        (exe_op),
        .exe_wb        (exe_wb),
        .exe_uuid      (exe_uuid),
        .exe_wid       (exe_wid),
        .exe_pc        (exe_pc),
        .exe_rd        (exe_rd),
        .align         (req_align),
        .mem_req_ready (mem_req_ready),
        .nrsp_ready    (nrsp_ready),
        .rsp_fire      (rsp_fire),
        .rsp_is_fence  (rsp_is_fence),
        .exe_ready     (exe_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req_rw    (mem_req_rw),
        .mem_req_flush (mem_req_flush),
        .mem_req_tag   (mem_req_tag),
        .nrsp_valid    (nrsp_valid)
    );

    lsu_rsp_format i_rsp_format (
        .mem_rsp_tag  (mem_rsp_tag),
        .mem_rsp_data (mem_rsp_data),
        .rsp_uuid     (rsp_uuid),
        .rsp_wid      (rsp_wid),
        .rsp_pc       (rsp_pc),
        .rsp_wb       (rsp_wb),
        .rsp_rd       (rsp_rd),
        .rsp_is_fence (rsp_is_fence),
        .rsp_data     (rsp_data)
    );

    lsu_commit_buf #(
        .WIDTH (RSP_W)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (mem_rsp_valid),
        .data_in   ({rsp_uuid, rsp_wid, mem_rsp_mask, rsp_pc, rsp_wb, rsp_rd, rsp_data}),
        .ready_out (rsp_buf_ready),
        .ready_in  (mem_rsp_ready),
        .valid_out (rsp_buf_valid),
        .data_out  (rsp_buf_data)
    );

    // stores without writeback, captured with their request
    lsu_commit_buf #(
        .WIDTH (NRSP_W)
    ) nrsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (nrsp_valid),
        .data_in   ({exe_uuid, exe_wid, exe_tmask, exe_pc}),
        .ready_out (nrsp_buf_ready),
        .ready_in  (nrsp_ready),
        .valid_out (nrsp_buf_valid),
        .data_out  (nrsp_buf_data)
    );

    lsu_commit_arb #(
        .WIDTH (RSP_W)
    ) i_commit_arb (
        .clk          (clk),
        .reset        (reset),
        .rsp_valid    (rsp_buf_valid),
        .rsp_data     (rsp_buf_data),
        .nrsp_valid   (nrsp_buf_valid),
        .nrsp_data    ({nrsp_buf_data, 1'b0, {`LSU_NR_W{1'b0}},
                        {(`LSU_NUM_LANES*`LSU_XLEN){1'b0}}}),
        .commit_ready (commit_ready),
        .rsp_ready    (rsp_buf_ready),
        .nrsp_ready   (nrsp_buf_ready),
        .commit_valid (commit_valid),
        .commit_data  (arb_data)
    );

    assign {
        commit_uuid,
        commit_wid,
        commit_tmask,
        commit_pc,
        commit_wb,
        commit_rd,
        commit_data
    } = arb_data;

endmodule

//--- tb_lsu_slice.sv
// testbench for the load/store slice: memory model, stimulus reader, commit checker and watchdog
`timescale 1ns/100ps
`include "lsu_params.svh"

module tb_lsu_slice;
    import lsu_pkg::*;

    localparam int NUM_LINES = 16;
    localparam int FIELDS    = 18;
    localparam int NL        = `LSU_NUM_LANES;
    localparam int MEM_WORDS = 64;

    logic clk = 1'b0;
    logic reset;

    // execute channel
    logic                  exe_valid;
    uuid_t                 exe_uuid;
    wid_t                  exe_wid;
    lane_mask_t            exe_tmask;
    pc_t                   exe_pc;
    lsu_op_e               exe_op;
    logic                  exe_wb;
    rd_t                   exe_rd;
    xword_t [NL-1:0]       exe_rs1_data;
    xword_t [NL-1:0]       exe_rs2_data;
    logic [`LSU_OFFSET_W-1:0] exe_offset;
    logic                  exe_ready;

    // memory request channel
    logic                  mem_req_valid;
    logic                  mem_req_rw;
    lane_mask_t            mem_req_mask;
    byteen_t [NL-1:0]      mem_req_byteen;
    maddr_t [NL-1:0]       mem_req_addr;
    xword_t [NL-1:0]       mem_req_data;
    logic                  mem_req_flush;
    mem_tag_t              mem_req_tag;
    logic                  mem_req_ready = 1'b0;

    // memory response channel
    logic                  mem_rsp_valid = 1'b0;
    lane_mask_t            mem_rsp_mask = '0;
    xword_t [NL-1:0]       mem_rsp_data = '0;
    mem_tag_t              mem_rsp_tag = '0;
    logic                  mem_rsp_ready;

    // commit channel
    logic                  commit_valid;
    uuid_t                 commit_uuid;
    wid_t                  commit_wid;
    lane_mask_t            commit_tmask;
    pc_t                   commit_pc;
    logic                  commit_wb;
    rd_t                   commit_rd;
    xword_t [NL-1:0]       commit_data;
    logic                  commit_ready = 1'b0;

    logic [31:0] stim [NUM_LINES*FIELDS];
    logic [31:0] mem [MEM_WORDS];

    // expected commit fields by uuid
    logic [NL*32-1:0] exp_data [256];
    logic             exp_wb [256];
    rd_t              exp_rd [256];
    lane_mask_t       exp_tmask [256];
    wid_t             exp_wid [256];
    pc_t              exp_pc [256];
    bit               issued [256];
    bit               committed [256];

    // pending memory responses
    mem_tag_t         rsp_tag_q [$];
    logic [NL*32-1:0] rsp_data_q [$];
    lane_mask_t       rsp_mask_q [$];
    bit               rsp_fence_q [$];
    int               rsp_idx;
    bit               rsp_hold;
    bit               fence_pending;

    integer seed = 56347;
    int     value_errors;
    int     protocol_errors;
    int     issued_count;
    int     commit_count;

    lsu_slice i_dut (
        .clk            (clk),
        .reset          (reset),
        .exe_valid      (exe_valid),
        .exe_uuid       (exe_uuid),
        .exe_wid        (exe_wid),
        .exe_tmask      (exe_tmask),
        .exe_pc         (exe_pc),
        .exe_op         (exe_op),
        .exe_wb         (exe_wb),
        .exe_rd         (exe_rd),
        .exe_rs1_data   (exe_rs1_data),
        .exe_rs2_data   (exe_rs2_data),
        .exe_offset     (exe_offset),
        .exe_ready      (exe_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_rw     (mem_req_rw),
        .mem_req_mask   (mem_req_mask),
        .mem_req_byteen (mem_req_byteen),
        .mem_req_addr   (mem_req_addr),
        .mem_req_data   (mem_req_data),
        .mem_req_flush  (mem_req_flush),
        .mem_req_tag    (mem_req_tag),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp_mask   (mem_rsp_mask),
        .mem_rsp_data   (mem_rsp_data),
        .mem_rsp_tag    (mem_rsp_tag),
        .mem_rsp_ready  (mem_rsp_ready),
        .commit_valid   (commit_valid),
        .commit_uuid    (commit_uuid),
        .commit_wid     (commit_wid),
        .commit_tmask   (commit_tmask),
        .commit_pc      (commit_pc),
        .commit_wb      (commit_wb),
        .commit_rd      (commit_rd),
        .commit_data    (commit_data),
        .commit_ready   (commit_ready)
    );

    always #20 clk = ~clk;

    task automatic compare_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            value_errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, actual, expected);
        end
    endtask

    // one byte, an aligned pair or the whole word
    function automatic byteen_t expected_byteen(lsu_op_e op, logic [1:0] ofs);
        case (op)
            LB, LBU, SB: return 4'b0001 << ofs;
            LH, LHU, SH: return 4'b0011 << {ofs[1], 1'b0};
            default:     return 4'b1111;
        endcase
    endfunction

    function automatic bit is_store(lsu_op_e op);
        return (op == SB) || (op == SH) || (op == SW);
    endfunction

    task automatic apply_line(int n);
        int    b;
        uuid_t u;
        b = n * FIELDS;
        u = stim[b+3][7:0];
        exe_op     <= lsu_op_e'(stim[b][3:0]);
        exe_wb     <= stim[b+1][0];
        exe_rd     <= stim[b+2][4:0];
        exe_uuid   <= u;
        exe_wid    <= u[1:0];
        exe_pc     <= pc_t'(32'h400 + u);
        exe_tmask  <= stim[b+4][3:0];
        exe_offset <= stim[b+13][`LSU_OFFSET_W-1:0];
        exe_valid  <= 1'b1;
        for (int l = 0; l < NL; l++) begin
            exe_rs1_data[l] <= stim[b+5+l];
            exe_rs2_data[l] <= stim[b+9+l];
            exp_data[u][32*l +: 32] = stim[b+14+l];
        end
        // stores commit with rd cleared
        exp_wb[u]    = stim[b+1][0];
        exp_rd[u]    = is_store(lsu_op_e'(stim[b][3:0])) ? '0 : stim[b+2][4:0];
        exp_tmask[u] = stim[b+4][3:0];
        exp_wid[u]   = u[1:0];
        exp_pc[u]    = pc_t'(32'h400 + u);
    endtask

    task automatic capture_request();
        logic [31:0]      addr;
        logic [5:0]       idx;
        logic [NL*32-1:0] rdata;
        rdata = '0;
        if (fence_pending) begin
            protocol_errors++;
            $display("memory request for uuid %0h issued while a fence is outstanding",
                     exe_uuid);
        end
        compare_value("mem_req_mask", mem_req_mask, exe_tmask);
        compare_value("mem_req_rw", mem_req_rw, is_store(exe_op));
        compare_value("mem_req_flush", mem_req_flush, exe_op == FENCE);
        for (int l = 0; l < NL; l++) begin
            addr = exe_rs1_data[l] + {{(32-`LSU_OFFSET_W){exe_offset[`LSU_OFFSET_W-1]}},
                                      exe_offset};
            idx  = mem_req_addr[l][5:0];
            if (mem_req_mask[l] && exe_op != FENCE) begin
                compare_value($sformatf("mem_req_addr[%0d]", l), mem_req_addr[l], addr[31:2]);
                compare_value($sformatf("mem_req_byteen[%0d]", l), mem_req_byteen[l],
                              expected_byteen(exe_op, addr[1:0]));
                if (mem_req_rw) begin
                    compare_value($sformatf("mem_req_data[%0d]", l), mem_req_data[l],
                                  exe_rs2_data[l] << (8 * addr[1:0]));
                    for (int k = 0; k < 4; k++) begin
                        if (mem_req_byteen[l][k]) begin
                            mem[idx][8*k +: 8] = mem_req_data[l][8*k +: 8];
                        end
                    end
                end else begin
                    rdata[32*l +: 32] = mem[idx];
                end
            end
        end
        // stores get no response
        if (!mem_req_rw) begin
            rsp_tag_q.push_back(mem_req_tag);
            rsp_data_q.push_back(rdata);
            rsp_mask_q.push_back(mem_req_mask);
            rsp_fence_q.push_back(mem_req_flush);
        end
        if (mem_req_flush) begin
            fence_pending = 1'b1;
        end
    endtask

    task automatic check_commit();
        uuid_t u;
        u = commit_uuid;
        if (!issued[u]) begin
            protocol_errors++;
            $display("commit for uuid %0h that was never issued", u);
        end else if (committed[u]) begin
            protocol_errors++;
            $display("uuid %0h committed more than once", u);
        end else begin
            committed[u] = 1'b1;
            commit_count++;
            compare_value($sformatf("commit_wb uuid %0h", u), commit_wb, exp_wb[u]);
            compare_value($sformatf("commit_rd uuid %0h", u), commit_rd, exp_rd[u]);
            compare_value($sformatf("commit_wid uuid %0h", u), commit_wid, exp_wid[u]);
            compare_value($sformatf("commit_pc uuid %0h", u), commit_pc, exp_pc[u]);
            compare_value($sformatf("commit_tmask uuid %0h", u), commit_tmask, exp_tmask[u]);
            for (int l = 0; l < NL; l++) begin
                if (exp_tmask[u][l]) begin
                    compare_value($sformatf("commit_data[%0d] uuid %0h", l, u),
                                  commit_data[l], exp_data[u][32*l +: 32]);
                end
            end
        end
    endtask

    // memory model with random back-pressure and out-of-order responses
    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            commit_ready  <= 1'b0;
            fence_pending = 1'b0;
        end else begin
            if (mem_req_valid && mem_req_ready) begin
                capture_request();
            end
            rsp_hold = mem_rsp_valid && !mem_rsp_ready;
            if (mem_rsp_valid && mem_rsp_ready) begin
                if (rsp_fence_q[rsp_idx]) begin
                    fence_pending = 1'b0;
                end
                rsp_tag_q.delete(rsp_idx);
                rsp_data_q.delete(rsp_idx);
                rsp_mask_q.delete(rsp_idx);
                rsp_fence_q.delete(rsp_idx);
            end
            if (!rsp_hold) begin
                if (rsp_tag_q.size() > 0 && ($random(seed) & 1)) begin
                    rsp_idx = ($random(seed) & 32'h7fff_ffff) % rsp_tag_q.size();
                    mem_rsp_valid <= 1'b1;
                    mem_rsp_tag   <= rsp_tag_q[rsp_idx];
                    mem_rsp_data  <= rsp_data_q[rsp_idx];
                    mem_rsp_mask  <= rsp_mask_q[rsp_idx];
                end else begin
                    mem_rsp_valid <= 1'b0;
                end
            end
            mem_req_ready <= ($random(seed) & 3) != 0;
            commit_ready  <= ($random(seed) & 3) != 0;
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            if (commit_valid && issued_count == 0) begin
                protocol_errors++;
                $display("commit seen before any instruction was issued");
            end
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (exe_valid && exe_ready) begin
                issued[exe_uuid] = 1'b1;
                issued_count++;
            end
        end
    end

    initial begin
        for (int a = 0; a < MEM_WORDS; a++) begin
            mem[a] = a * 32'h0101_0101;
        end
        exe_valid    = 1'b0;
        exe_uuid     = '0;
        exe_wid      = '0;
        exe_tmask    = '0;
        exe_pc       = '0;
        exe_op       = LW;
        exe_wb       = 1'b0;
        exe_rd       = '0;
        exe_rs1_data = '0;
        exe_rs2_data = '0;
        exe_offset   = '0;
        reset        = 1'b1;
        $readmemh("lsu_stimulus.txt", stim);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < NUM_LINES; n++) begin
            apply_line(n);
            @(posedge clk);
            while (!exe_ready) begin
                @(posedge clk);
            end
        end
        exe_valid <= 1'b0;
        while (commit_count < NUM_LINES) begin
            @(negedge clk);
        end
        // late duplicates would show up here
        repeat (20) @(posedge clk);
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors + protocol_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin
        repeat (10 + NUM_LINES * 200) @(posedge clk);
        $display("timeout: only %0d of %0d instructions committed", commit_count, NUM_LINES);
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- lsu_stimulus.txt
// op wb rd uuid tmask | rs1 lanes 0-3 | rs2 lanes 0-3 | offset | expected commit data lanes 0-3
// op codes 0 lb, 1 lh, 2 lw, 4 lbu, 5 lhu, 8 sb, 9 sh, a sw, f fence; all values hex
a 0 03 01 f 40 44 48 4c 8899aabb 11223344 f0e1d2c3 7f8081fe 000 0 0 0 0
0 1 01 02 f 40 41 42 43 0 0 0 0 000 ffffffbb ffffffaa ffffff99 ffffff88
4 1 02 03 f 44 45 46 47 0 0 0 0 000 44 33 22 11
1 1 04 04 f 48 4a 40 42 0 0 0 0 000 ffffd2c3 fffff0e1 ffffaabb ffff8899
5 1 05 05 f 4c 4e 44 46 0 0 0 0 000 81fe 7f80 3344 1122
f 0 00 06 f 0 0 0 0 0 0 0 0 000 0 0 0 0
8 0 07 07 f 80 85 8a 8f a1 b2 c3 d4 000 0 0 0 0
9 0 08 08 f 90 96 98 9e 5566 e7e8 0102 fedc 000 0 0 0 0
2 1 09 09 f 80 84 88 8c 0 0 0 0 000 202020a1 2121b221 22c32222 d4232323
2 1 0a 0a f 90 94 98 9c 0 0 0 0 000 24245566 e7e82525 26260102 fedc2727
0 1 0b 0b f 8b 8d 8f 91 0 0 0 0 ffe 22 22 23 ffffffd4
f 0 00 0c f 0 0 0 0 0 0 0 0 000 0 0 0 0
a 0 0d 0d 5 a0 a4 a8 ac cafef00d 0badbeef 12345678 9abcdef0 000 0 0 0 0
2 1 0e 0e f a0 a4 a8 ac 0 0 0 0 000 cafef00d 29292929 12345678 2b2b2b2b
5 1 0f 0f 6 0 9e 80 0 0 0 0 0 002 0 f00d 2020 0
0 1 10 10 f a0 a1 a2 a3 0 0 0 0 000 0000000d fffffff0 fffffffe ffffffca

//--- sources.f
+incdir+.
lsu_pkg.sv
lsu_req_format.sv
lsu_issue_ctrl.sv
lsu_rsp_format.sv
lsu_commit_buf.sv
lsu_commit_arb.sv
lsu_slice.sv
tb_lsu_slice.sv

//--- Bender.yml
package:
  name: lsu_slice

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_req_format.sv
      - lsu_issue_ctrl.sv
      - lsu_rsp_format.sv
      - lsu_commit_buf.sv
      - lsu_commit_arb.sv
      - lsu_slice.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_lsu_slice.sv
